/* rtl/lsu_pkg.sv */
// shared widths, operation encoding and record types, referenced as lsu_pkg::name by RTL and testbench
package lsu_pkg;

    // ----------------------------------------------------------
    // widths and sizes
    // ----------------------------------------------------------
    localparam int XLEN       = 64;
    localparam int ADDR_W     = 32;
    localparam int TRANS_ID_W = 3;
    localparam int STQ_DEPTH  = 4;
    localparam int STQ_PTR_W  = $clog2(STQ_DEPTH);

    // exception causes as defined by the privileged spec
    localparam logic [XLEN-1:0] CAUSE_LD_MISALIGNED = XLEN'(4);
    localparam logic [XLEN-1:0] CAUSE_ST_MISALIGNED = XLEN'(6);

    // ----------------------------------------------------------
    // operations
    // ----------------------------------------------------------
    typedef enum logic [3:0] {
        LB  = 4'd0,
        LBU = 4'd1,
        LH  = 4'd2,
        LHU = 4'd3,
        LW  = 4'd4,
        LWU = 4'd5,
        LD  = 4'd6,
        SB  = 4'd7,
        SH  = 4'd8,
        SW  = 4'd9,
        SD  = 4'd10
    } lsu_op_e;

    function automatic logic is_store(lsu_op_e op);
        return op inside {SB, SH, SW, SD};
    endfunction

    // ----------------------------------------------------------
    // records
    // ----------------------------------------------------------
    // issue word from the scoreboard
    typedef struct packed {
        lsu_op_e               op;
        logic [XLEN-1:0]       operand_a;
        logic [XLEN-1:0]       operand_b;
        logic [XLEN-1:0]       imm;
        logic [TRANS_ID_W-1:0] trans_id;
    } fu_data_t;

    // request after address generation, store data already in its lane
    typedef struct packed {
        logic                  valid;
        logic [ADDR_W-1:0]     vaddr;
        logic                  misaligned;
        logic [XLEN-1:0]       data;
        logic [7:0]            be;
        lsu_op_e               op;
        logic [TRANS_ID_W-1:0] trans_id;
    } lsu_req_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] cause;
        logic [XLEN-1:0] tval;
    } exception_t;

    typedef struct packed {
        logic                  valid;
        logic [TRANS_ID_W-1:0] trans_id;
        logic [XLEN-1:0]       result;
        exception_t            ex;
    } wb_t;

    // addr is always dword aligned
    typedef struct packed {
        logic              req;
        logic              we;
        logic [ADDR_W-1:0] addr;
        logic [7:0]        be;
        logic [XLEN-1:0]   wdata;
    } mem_req_t;

    typedef struct packed {
        logic            gnt;
        logic            rvalid;
        logic [XLEN-1:0] rdata;
    } mem_resp_t;

endpackage

/* rtl/lsu_agu.sv */
// address generation unit: computes address, byte enables, store lane data and misalignment
`timescale 1ns/10ps

module lsu_agu (
    input  lsu_pkg::fu_data_t fu_data_i,
    input  logic              valid_i,
    output lsu_pkg::lsu_req_t req_o
);

    logic [lsu_pkg::XLEN-1:0] vaddr_full;
    logic [2:0]               off;
    logic [1:0]               size;
    logic [7:0]               be;
    logic                     misaligned;

    // base plus sign-extended immediate
    assign vaddr_full = lsu_pkg::XLEN'($signed(fu_data_i.operand_a) + $signed(fu_data_i.imm));
    assign off        = vaddr_full[2:0];

    // access size as log2 of the byte count
    always_comb begin
        case (fu_data_i.op)
            lsu_pkg::LB, lsu_pkg::LBU, lsu_pkg::SB: size = 2'd0;
            lsu_pkg::LH, lsu_pkg::LHU, lsu_pkg::SH: size = 2'd1;
            lsu_pkg::LW, lsu_pkg::LWU, lsu_pkg::SW: size = 2'd2;
            default:                                size = 2'd3;
        endcase
    end

    // ----------------------------------------------------------
    // byte enables and misalignment
    // ----------------------------------------------------------
    always_comb begin
        case (size)
            2'd0: begin
                be         = 8'h01 << off;
                misaligned = 1'b0;
            end
            2'd1: begin
                be         = 8'h03 << off;
                misaligned = off[0];
            end
            2'd2: begin
                be         = 8'h0f << off;
                misaligned = |off[1:0];
            end
            default: begin
                be         = 8'hff;
                misaligned = |off;
            end
        endcase
    end

    always_comb begin
        req_o            = '0;
        req_o.valid      = valid_i;
        req_o.vaddr      = vaddr_full[lsu_pkg::ADDR_W-1:0];
        req_o.misaligned = misaligned;
        // store data moves into the lane selected by the low address bits
        req_o.data       = fu_data_i.operand_b << {off, 3'b000};
        req_o.be         = be;
        req_o.op         = fu_data_i.op;
        req_o.trans_id   = fu_data_i.trans_id;
    end

endmodule

/* rtl/lsu_bypass.sv */
// two-entry request buffer that holds issued operations while the load or store unit is busy
`timescale 1ns/10ps

module lsu_bypass (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic              flush_i,
    input  lsu_pkg::lsu_req_t req_i,
    input  logic              pop_ld_i,
    input  logic              pop_st_i,
    output lsu_pkg::lsu_req_t ctrl_o,
    output logic              ready_o
);

    lsu_pkg::lsu_req_t [1:0] mem_d, mem_q;
    logic                    wptr_d, wptr_q;
    logic                    rptr_d, rptr_q;
    logic [1:0]              cnt_d, cnt_q;
    logic                    empty;

    assign empty   = (cnt_q == 2'd0);
    assign ready_o = empty;

    // an empty buffer lets the new request through in the same cycle
    assign ctrl_o = empty ? req_i : mem_q[rptr_q];

    always_comb begin
        mem_d  = mem_q;
        wptr_d = wptr_q;
        rptr_d = rptr_q;
        cnt_d  = cnt_q;

        if (req_i.valid) begin
            mem_d[wptr_q] = req_i;
            wptr_d        = wptr_q + 1'b1;
            cnt_d         = cnt_d + 2'd1;
        end

        // only one entry is presented, so at most one unit pops
        if (pop_ld_i || pop_st_i) begin
            mem_d[rptr_q].valid = 1'b0;
            rptr_d              = rptr_q + 1'b1;
            cnt_d               = cnt_d - 2'd1;
        end

        if (flush_i) begin
            mem_d  = '0;
            wptr_d = 1'b0;
            rptr_d = 1'b0;
            cnt_d  = 2'd0;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            mem_q  <= '0;
            wptr_q <= 1'b0;
            rptr_q <= 1'b0;
            cnt_q  <= 2'd0;
        end else begin
            mem_q  <= mem_d;
            wptr_q <= wptr_d;
            rptr_q <= rptr_d;
            cnt_q  <= cnt_d;
        end
    end

endmodule

/* rtl/load_unit.sv */
// load unit: waits on store hazards, reads memory and writes back the extended result
`timescale 1ns/10ps

module load_unit (
    input  logic                        clk_i,
    input  logic                        rst_ni,
    input  logic                        flush_i,
    input  lsu_pkg::lsu_req_t           ctrl_i,
    output logic                        pop_ld_o,
    output logic [lsu_pkg::ADDR_W-1:0]  ld_dword_addr_o,
    input  logic                        stq_match_i,
    output lsu_pkg::mem_req_t           mem_o,
    input  lsu_pkg::mem_resp_t          mem_i,
    output lsu_pkg::wb_t                wb_o
);

    typedef enum logic [2:0] {
        IDLE,
        WAIT_HAZARD,
        REQUEST,
        WAIT_DATA,
        REPORT
    } state_e;

    state_e                   state_q;
    lsu_pkg::lsu_req_t        ld_q;
    logic                     killed_q;
    lsu_pkg::wb_t             wb_q;
    logic                     take;
    logic [lsu_pkg::XLEN-1:0] shifted;
    logic [lsu_pkg::XLEN-1:0] ld_result;

    assign take = (state_q == IDLE) && ctrl_i.valid && !lsu_pkg::is_store(ctrl_i.op) && !flush_i;
    assign pop_ld_o        = take;
    assign ld_dword_addr_o = {ld_q.vaddr[lsu_pkg::ADDR_W-1:3], 3'b000};
    assign wb_o            = wb_q;

    always_comb begin
        mem_o       = '0;
        mem_o.req   = (state_q == REQUEST);
        mem_o.addr  = ld_dword_addr_o;
        mem_o.be    = ld_q.be;
    end

    // ----------------------------------------------------------
    // byte select and extension
    // ----------------------------------------------------------
    always_comb begin
        shifted = mem_i.rdata >> {ld_q.vaddr[2:0], 3'b000};
        case (ld_q.op)
            lsu_pkg::LB:  ld_result = {{(lsu_pkg::XLEN-8){shifted[7]}}, shifted[7:0]};
            lsu_pkg::LBU: ld_result = {{(lsu_pkg::XLEN-8){1'b0}}, shifted[7:0]};
            lsu_pkg::LH:  ld_result = {{(lsu_pkg::XLEN-16){shifted[15]}}, shifted[15:0]};
            lsu_pkg::LHU: ld_result = {{(lsu_pkg::XLEN-16){1'b0}}, shifted[15:0]};
            lsu_pkg::LW:  ld_result = {{(lsu_pkg::XLEN-32){shifted[31]}}, shifted[31:0]};
            lsu_pkg::LWU: ld_result = {{(lsu_pkg::XLEN-32){1'b0}}, shifted[31:0]};
            default:      ld_result = shifted;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (take) begin
            ld_q <= ctrl_i;
        end
    end

    // ----------------------------------------------------------
    // sequencing
    // ----------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q  <= IDLE;
            killed_q <= 1'b0;
            wb_q     <= '0;
        end else begin
            wb_q.valid <= 1'b0;
            // a granted read must still finish, so flush only marks it
            if (flush_i) begin
                killed_q <= 1'b1;
            end
            case (state_q)
                IDLE: begin
                    if (take) begin
                        killed_q <= 1'b0;
                        if (ctrl_i.misaligned) begin
                            wb_q.valid    <= 1'b1;
                            wb_q.trans_id <= ctrl_i.trans_id;
                            wb_q.result   <= '0;
                            wb_q.ex.valid <= 1'b1;
                            wb_q.ex.cause <= lsu_pkg::CAUSE_LD_MISALIGNED;
                            wb_q.ex.tval  <= lsu_pkg::XLEN'(ctrl_i.vaddr);
                            state_q       <= REPORT;
                        end else begin
                            state_q <= WAIT_HAZARD;
                        end
                    end
                end
                WAIT_HAZARD: begin
                    if (flush_i) begin
                        state_q <= IDLE;
                    end else if (!stq_match_i) begin
                        state_q <= REQUEST;
                    end
                end
                REQUEST: begin
                    if (mem_i.gnt) begin
                        state_q <= WAIT_DATA;
                    end
                end
                WAIT_DATA: begin
                    if (mem_i.rvalid) begin
                        wb_q.valid    <= !(killed_q || flush_i);
                        wb_q.trans_id <= ld_q.trans_id;
                        wb_q.result   <= ld_result;
                        wb_q.ex       <= '0;
                        state_q       <= (killed_q || flush_i) ? IDLE : REPORT;
                    end
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

endmodule

/* rtl/store_unit.sv */
// store unit: writes back stores at once, queues them until commit and drains committed ones to memory
`timescale 1ns/10ps

module store_unit (
    input  logic                        clk_i,
    input  logic                        rst_ni,
    input  logic                        flush_i,
    input  lsu_pkg::lsu_req_t           ctrl_i,
    output logic                        pop_st_o,
    input  logic                        commit_i,
    output logic                        commit_ready_o,
    output logic                        no_st_pending_o,
    input  logic [lsu_pkg::ADDR_W-1:0]  ld_dword_addr_i,
    output logic                        stq_match_o,
    output lsu_pkg::mem_req_t           mem_o,
    input  lsu_pkg::mem_resp_t          mem_i,
    output lsu_pkg::wb_t                wb_o
);

    localparam int DEPTH = lsu_pkg::STQ_DEPTH;
    localparam int PTR_W = lsu_pkg::STQ_PTR_W;

    logic [DEPTH-1:0]          valid_q;
    logic [DEPTH-1:0]          committed_q;
    // dword index only, the low three bits are always zero
    logic [lsu_pkg::ADDR_W-4:0] addr_q [DEPTH];
    logic [lsu_pkg::XLEN-1:0]   data_q [DEPTH];
    logic [7:0]                 be_q   [DEPTH];
    logic [PTR_W-1:0]           wr_ptr_q;
    logic [PTR_W-1:0]           commit_ptr_q;
    logic [PTR_W-1:0]           drain_ptr_q;
    logic                       full;
    logic                       take;
    logic                       drain;
    lsu_pkg::wb_t               wb_q;

    assign full  = valid_q[wr_ptr_q];
    assign take  = ctrl_i.valid && lsu_pkg::is_store(ctrl_i.op) && !full && !flush_i;
    assign drain = mem_o.req && mem_i.gnt;

    assign pop_st_o        = take;
    assign commit_ready_o  = valid_q[commit_ptr_q] && !committed_q[commit_ptr_q];
    assign no_st_pending_o = ~|valid_q;
    assign wb_o            = wb_q;

    // oldest committed entry goes to memory
    always_comb begin
        mem_o       = '0;
        mem_o.req   = valid_q[drain_ptr_q] && committed_q[drain_ptr_q];
        mem_o.we    = 1'b1;
        mem_o.addr  = {addr_q[drain_ptr_q], 3'b000};
        mem_o.be    = be_q[drain_ptr_q];
        mem_o.wdata = data_q[drain_ptr_q];
    end

    // loads to a dword that any queued store touches must wait
    always_comb begin
        stq_match_o = 1'b0;
        for (int i = 0; i < DEPTH; i++) begin
            if (valid_q[i] && addr_q[i] == ld_dword_addr_i[lsu_pkg::ADDR_W-1:3]) begin
                stq_match_o = 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (take && !ctrl_i.misaligned) begin
            addr_q[wr_ptr_q] <= ctrl_i.vaddr[lsu_pkg::ADDR_W-1:3];
            data_q[wr_ptr_q] <= ctrl_i.data;
            be_q[wr_ptr_q]   <= ctrl_i.be;
        end
    end

    // ----------------------------------------------------------
    // queue control and writeback
    // ----------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q      <= '0;
            committed_q  <= '0;
            wr_ptr_q     <= '0;
            commit_ptr_q <= '0;
            drain_ptr_q  <= '0;
            wb_q         <= '0;
        end else begin
            wb_q.valid <= 1'b0;
            if (take) begin
                wb_q.valid    <= 1'b1;
                wb_q.trans_id <= ctrl_i.trans_id;
                wb_q.result   <= '0;
                wb_q.ex.valid <= ctrl_i.misaligned;
                wb_q.ex.cause <= ctrl_i.misaligned ? lsu_pkg::CAUSE_ST_MISALIGNED : '0;
                wb_q.ex.tval  <= ctrl_i.misaligned ? lsu_pkg::XLEN'(ctrl_i.vaddr) : '0;
                if (!ctrl_i.misaligned) begin
                    valid_q[wr_ptr_q]     <= 1'b1;
                    committed_q[wr_ptr_q] <= 1'b0;
                    wr_ptr_q              <= wr_ptr_q + 1'b1;
                end
            end
            if (commit_i) begin
                committed_q[commit_ptr_q] <= 1'b1;
                commit_ptr_q              <= commit_ptr_q + 1'b1;
            end
            if (drain) begin
                valid_q[drain_ptr_q] <= 1'b0;
                drain_ptr_q          <= drain_ptr_q + 1'b1;
            end
            // speculative entries are dropped, a commit in the same cycle survives
            if (flush_i) begin
                for (int i = 0; i < DEPTH; i++) begin
                    if (!committed_q[i] && !(commit_i && PTR_W'(i) == commit_ptr_q)) begin
                        valid_q[i] <= 1'b0;
                    end
                end
                wr_ptr_q <= commit_ptr_q + PTR_W'(commit_i);
            end
        end
    end

endmodule

/* rtl/load_store_unit.sv */
// load/store unit top level connecting address generation, request buffer and the two units
`timescale 1ns/10ps

module load_store_unit (
    input  logic               clk_i,
    input  logic               rst_ni,
    input  logic               flush_i,
    input  lsu_pkg::fu_data_t  fu_data_i,
    input  logic               lsu_valid_i,
    output logic               lsu_ready_o,
    output lsu_pkg::wb_t       load_wb_o,
    output lsu_pkg::wb_t       store_wb_o,
    input  logic               commit_i,
    output logic               commit_ready_o,
    output logic               no_st_pending_o,
    output lsu_pkg::mem_req_t  ld_mem_o,
    input  lsu_pkg::mem_resp_t ld_mem_i,
    output lsu_pkg::mem_req_t  st_mem_o,
    input  lsu_pkg::mem_resp_t st_mem_i
);

    lsu_pkg::lsu_req_t          agu_req;
    lsu_pkg::lsu_req_t          lsu_ctrl;
    logic                       pop_ld;
    logic                       pop_st;
    logic [lsu_pkg::ADDR_W-1:0] ld_dword_addr;
    logic                       stq_match;

    lsu_agu i_agu (
        .fu_data_i (fu_data_i),
        .valid_i   (lsu_valid_i),
        .req_o     (agu_req)
    );

    lsu_bypass i_bypass (
        .clk_i    (clk_i),
        .rst_ni   (rst_ni),
        .flush_i  (flush_i),
        .req_i    (agu_req),
        .pop_ld_i (pop_ld),
        .pop_st_i (pop_st),
        .ctrl_o   (lsu_ctrl),
        .ready_o  (lsu_ready_o)
    );

    load_unit i_load_unit (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .flush_i         (flush_i),
        .ctrl_i          (lsu_ctrl),
        .pop_ld_o        (pop_ld),
        .ld_dword_addr_o (ld_dword_addr),
        .stq_match_i     (stq_match),
        .mem_o           (ld_mem_o),
        .mem_i           (ld_mem_i),
        .wb_o            (load_wb_o)
    );

    store_unit i_store_unit (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .flush_i         (flush_i),
        .ctrl_i          (lsu_ctrl),
        .pop_st_o        (pop_st),
        .commit_i        (commit_i),
        .commit_ready_o  (commit_ready_o),
        .no_st_pending_o (no_st_pending_o),
        .ld_dword_addr_i (ld_dword_addr),
        .stq_match_o     (stq_match),
        .mem_o           (st_mem_o),
        .mem_i           (st_mem_i),
        .wb_o            (store_wb_o)
    );

endmodule

/* include/lsu_tb_tasks.svh */
// directed test tasks and the check and wait helpers, included inside the tb_lsu module
`ifndef LSU_TB_TASKS_SVH
`define LSU_TB_TASKS_SVH

    task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
        assert (got == exp) else begin
            $display("FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
            report_fail();
        end
    endtask

    // ----------------------------------------------------------
    // wait helpers, all entered and left 1 ns after a rising edge
    // ----------------------------------------------------------
    task automatic wait_ready();
        int n;
        n = 0;
        while (!lsu_ready_o) begin
            if (n == WAIT_MAX) begin
                $display("timeout waiting for lsu_ready_o");
                report_fail();
            end
            n++;
            @(posedge clk_i);
            #1;
        end
    endtask

    task automatic wait_wb(input logic is_load, output lsu_pkg::wb_t wb);
        int n;
        n = 0;
        while (!(is_load ? load_wb_o.valid : store_wb_o.valid)) begin
            if (n == WAIT_MAX) begin
                $display("timeout waiting for a %s writeback", is_load ? "load" : "store");
                report_fail();
            end
            n++;
            @(posedge clk_i);
            #1;
        end
        wb = is_load ? load_wb_o : store_wb_o;
    endtask

    task automatic wait_no_pending();
        int n;
        n = 0;
        while (!no_st_pending_o) begin
            if (n == WAIT_MAX) begin
                $display("timeout waiting for the store queue to empty");
                report_fail();
            end
            n++;
            @(posedge clk_i);
            #1;
        end
    endtask

    task automatic commit_store();
        int n;
        n = 0;
        while (!commit_ready_o) begin
            if (n == WAIT_MAX) begin
                $display("timeout waiting for commit_ready_o");
                report_fail();
            end
            n++;
            @(posedge clk_i);
            #1;
        end
        commit_i = 1'b1;
        @(posedge clk_i);
        #1;
        commit_i = 1'b0;
    endtask

    // ----------------------------------------------------------
    // issue and directed operations
    // ----------------------------------------------------------
    task automatic issue_op(input lsu_pkg::lsu_op_e op, input logic [31:0] addr,
                            input logic [63:0] data, input logic [2:0] id);
        logic [63:0] imm;
        // odd ids use a negative immediate
        imm = id[0] ? 64'hffff_ffff_ffff_f018 : 64'h0000_0000_0000_0028;
        wait_ready();
        fu_data_i.op        = op;
        fu_data_i.operand_a = 64'(addr) - imm;
        fu_data_i.operand_b = data;
        fu_data_i.imm       = imm;
        fu_data_i.trans_id  = id;
        lsu_valid_i         = 1'b1;
        @(posedge clk_i);
        #1;
        lsu_valid_i = 1'b0;
    endtask

    task automatic do_store(input lsu_pkg::lsu_op_e op, input logic [31:0] addr,
                            input logic [63:0] data, input logic commit);
        lsu_pkg::wb_t wb;
        logic [2:0]   id;
        id      = next_id;
        next_id = next_id + 3'd1;
        issue_op(op, addr, data, id);
        wait_wb(1'b0, wb);
        check_val("store_wb_o.trans_id", 64'(wb.trans_id), 64'(id));
        check_val("store_wb_o.result", wb.result, 64'h0);
        check_val("store_wb_o.ex.valid", 64'(wb.ex.valid), 64'h0);
        if (commit) begin
            commit_store();
            apply_store(op, addr, data);
        end
    endtask

    task automatic do_load(input lsu_pkg::lsu_op_e op, input logic [31:0] addr);
        lsu_pkg::wb_t wb;
        logic [2:0]   id;
        id      = next_id;
        next_id = next_id + 3'd1;
        issue_op(op, addr, 64'h0, id);
        wait_wb(1'b1, wb);
        check_val("load_wb_o.trans_id", 64'(wb.trans_id), 64'(id));
        check_val("load_wb_o.ex.valid", 64'(wb.ex.valid), 64'h0);
        check_val("load_wb_o.result", wb.result, expect_load(op, addr));
    endtask

    task automatic do_misaligned(input lsu_pkg::lsu_op_e op, input logic [31:0] addr);
        lsu_pkg::wb_t wb;
        logic [2:0]   id;
        logic         is_ld;
        id      = next_id;
        next_id = next_id + 3'd1;
        is_ld   = !(op inside {lsu_pkg::SB, lsu_pkg::SH, lsu_pkg::SW, lsu_pkg::SD});
        issue_op(op, addr, 64'hdead_beef_0bad_f00d, id);
        wait_wb(is_ld, wb);
        check_val("wb.trans_id", 64'(wb.trans_id), 64'(id));
        check_val("wb.ex.valid", 64'(wb.ex.valid), 64'h1);
        // load misaligned is cause 4, store misaligned is cause 6
        check_val("wb.ex.cause", wb.ex.cause, is_ld ? 64'd4 : 64'd6);
        check_val("wb.ex.tval", wb.ex.tval, 64'(addr));
    endtask

`endif

/* tb/tb_lsu.sv */
// testbench top for the load/store unit: clock, reset, memory model, reference memory and test sequence
`timescale 1ns/10ps

module tb_lsu;

    localparam int          CLK_HALF = 2;
    localparam int          WAIT_MAX = 200;
    localparam logic [31:0] DW_A     = 32'h0000_1000;
    localparam logic [31:0] DW_B     = 32'h0000_2040;
    localparam logic [31:0] DW_C     = 32'h0000_3008;
    localparam logic [31:0] DW_D     = 32'h0000_4010;

    logic               clk_i = 1'b0;
    logic               rst_ni;
    logic               flush_i;
    lsu_pkg::fu_data_t  fu_data_i;
    logic               lsu_valid_i;
    logic               lsu_ready_o;
    lsu_pkg::wb_t       load_wb_o;
    lsu_pkg::wb_t       store_wb_o;
    logic               commit_i;
    logic               commit_ready_o;
    logic               no_st_pending_o;
    lsu_pkg::mem_req_t  ld_mem_o;
    lsu_pkg::mem_resp_t ld_mem_i;
    lsu_pkg::mem_req_t  st_mem_o;
    lsu_pkg::mem_resp_t st_mem_i;

    logic [31:0]        lfsr;
    logic               rd_pending;
    logic [31:0]        rd_addr;
    logic [2:0]         next_id;
    // memory seen by the DUT, and the expected contents after committed stores
    logic [63:0]        mem_model [logic [31:0]];
    logic [63:0]        ref_mem [logic [31:0]];

    always #(CLK_HALF) clk_i = ~clk_i;

    load_store_unit uut (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .flush_i         (flush_i),
        .fu_data_i       (fu_data_i),
        .lsu_valid_i     (lsu_valid_i),
        .lsu_ready_o     (lsu_ready_o),
        .load_wb_o       (load_wb_o),
        .store_wb_o      (store_wb_o),
        .commit_i        (commit_i),
        .commit_ready_o  (commit_ready_o),
        .no_st_pending_o (no_st_pending_o),
        .ld_mem_o        (ld_mem_o),
        .ld_mem_i        (ld_mem_i),
        .st_mem_o        (st_mem_o),
        .st_mem_i        (st_mem_i)
    );

    // ----------------------------------------------------------
    // memory model
    // ----------------------------------------------------------
    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic lfsr_bit();
        logic fb;
        fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    // untouched dwords hold a pattern built from the whole address
    function automatic logic [63:0] fill_word(input logic [31:0] dw);
        return {dw ^ 32'h5a5a_c3c3, dw * 32'h9e37_79b9};
    endfunction

    function automatic logic [63:0] read_word(input logic [31:0] dw);
        if (mem_model.exists(dw)) begin
            return mem_model[dw];
        end
        return fill_word(dw);
    endfunction

    function automatic void write_bytes(input logic [31:0] dw, input logic [7:0] be,
                                        input logic [63:0] wdata);
        logic [63:0] w;
        int          i;
        w = read_word(dw);
        for (i = 0; i < 8; i++) begin
            if (be[i]) begin
                w[i*8 +: 8] = wdata[i*8 +: 8];
            end
        end
        mem_model[dw] = w;
    endfunction

    initial begin
        lfsr       = 32'ha635;
        rd_pending = 1'b0;
        rd_addr    = 32'h0;
        ld_mem_i   = '0;
        st_mem_i   = '0;
        forever begin
            @(posedge clk_i);
            #1;
            // a read granted last cycle answers now
            ld_mem_i.rvalid = rd_pending;
            ld_mem_i.rdata  = rd_pending ? read_word(rd_addr) : 64'h0;
            rd_pending      = 1'b0;
            ld_mem_i.gnt    = ld_mem_o.req ? lfsr_bit() : 1'b0;
            if (ld_mem_o.req && ld_mem_i.gnt) begin
                check_val("ld_mem_o.we", 64'(ld_mem_o.we), 64'h0);
                rd_pending = 1'b1;
                rd_addr    = ld_mem_o.addr;
            end
            st_mem_i.gnt = st_mem_o.req ? lfsr_bit() : 1'b0;
            if (st_mem_o.req && st_mem_i.gnt) begin
                check_val("st_mem_o.we", 64'(st_mem_o.we), 64'h1);
                write_bytes(st_mem_o.addr, st_mem_o.be, st_mem_o.wdata);
            end
        end
    end

    // ----------------------------------------------------------
    // reference memory and expected load results
    // ----------------------------------------------------------
    function automatic int op_bytes(input lsu_pkg::lsu_op_e op);
        case (op)
            lsu_pkg::LB, lsu_pkg::LBU, lsu_pkg::SB: return 1;
            lsu_pkg::LH, lsu_pkg::LHU, lsu_pkg::SH: return 2;
            lsu_pkg::LW, lsu_pkg::LWU, lsu_pkg::SW: return 4;
            default:                                return 8;
        endcase
    endfunction

    function automatic logic [63:0] golden_word(input logic [31:0] dw);
        if (ref_mem.exists(dw)) begin
            return ref_mem[dw];
        end
        return fill_word(dw);
    endfunction

    // store data bytes land at addr, addr+1, ...
    function automatic void apply_store(input lsu_pkg::lsu_op_e op, input logic [31:0] addr,
                                        input logic [63:0] data);
        logic [63:0] w;
        int          off;
        int          i;
        w   = golden_word({addr[31:3], 3'b000});
        off = int'(addr[2:0]);
        for (i = 0; i < op_bytes(op); i++) begin
            w[(off + i)*8 +: 8] = data[i*8 +: 8];
        end
        ref_mem[{addr[31:3], 3'b000}] = w;
    endfunction

    function automatic logic [63:0] expect_load(input lsu_pkg::lsu_op_e op,
                                                input logic [31:0] addr);
        logic [63:0] w;
        logic [63:0] r;
        int          off;
        int          n;
        int          i;
        w   = golden_word({addr[31:3], 3'b000});
        off = int'(addr[2:0]);
        n   = op_bytes(op);
        r   = 64'h0;
        for (i = 0; i < n; i++) begin
            r[i*8 +: 8] = w[(off + i)*8 +: 8];
        end
        // signed loads copy the top loaded bit upward
        if (op inside {lsu_pkg::LB, lsu_pkg::LH, lsu_pkg::LW} && r[n*8-1]) begin
            for (i = n * 8; i < 64; i++) begin
                r[i] = 1'b1;
            end
        end
        return r;
    endfunction

    task automatic report_fail();
        $display("** FAIL **");
        $fatal(1, "simulation stopped at the first error");
    endtask

`include "lsu_tb_tasks.svh"

    // ----------------------------------------------------------
    // test sequence
    // ----------------------------------------------------------
    task automatic test_reset_state();
        check_val("lsu_ready_o", 64'(lsu_ready_o), 64'h1);
        check_val("no_st_pending_o", 64'(no_st_pending_o), 64'h1);
        check_val("load_wb_o.valid", 64'(load_wb_o.valid), 64'h0);
        check_val("store_wb_o.valid", 64'(store_wb_o.valid), 64'h0);
        check_val("ld_mem_o.req", 64'(ld_mem_o.req), 64'h0);
        check_val("st_mem_o.req", 64'(st_mem_o.req), 64'h0);
        check_val("commit_ready_o", 64'(commit_ready_o), 64'h0);
    endtask

    task automatic test_sd_then_loads();
        do_store(lsu_pkg::SD, DW_A, 64'h81f2_63d4_a5b6_c7e8, 1'b1);
        do_load(lsu_pkg::LB, DW_A);
        do_load(lsu_pkg::LB, DW_A + 32'd5);
        do_load(lsu_pkg::LBU, DW_A + 32'd7);
        do_load(lsu_pkg::LH, DW_A + 32'd2);
        do_load(lsu_pkg::LH, DW_A + 32'd4);
        do_load(lsu_pkg::LHU, DW_A + 32'd6);
        do_load(lsu_pkg::LW, DW_A);
        do_load(lsu_pkg::LW, DW_A + 32'd4);
        do_load(lsu_pkg::LWU, DW_A + 32'd4);
        do_load(lsu_pkg::LD, DW_A);
    endtask

    task automatic test_partial_stores();
        do_load(lsu_pkg::LD, DW_B);
        do_store(lsu_pkg::SB, DW_B + 32'd1, 64'h0000_0000_0000_005a, 1'b1);
        do_store(lsu_pkg::SH, DW_B + 32'd2, 64'h0000_0000_0000_beef, 1'b1);
        do_store(lsu_pkg::SW, DW_B + 32'd4, 64'h0000_0000_1234_5678, 1'b1);
        do_load(lsu_pkg::LD, DW_B);
    endtask

    task automatic test_misaligned();
        do_misaligned(lsu_pkg::LH, DW_C + 32'd1);
        do_misaligned(lsu_pkg::LW, DW_C + 32'd2);
        do_misaligned(lsu_pkg::LD, DW_C + 32'd4);
        do_misaligned(lsu_pkg::SH, DW_C + 32'd3);
        do_misaligned(lsu_pkg::SW, DW_C + 32'd6);
        do_misaligned(lsu_pkg::SD, DW_C + 32'd1);
        do_load(lsu_pkg::LD, DW_C);
    endtask

    task automatic test_flush();
        do_store(lsu_pkg::SD, DW_D, 64'h0123_4567_89ab_cdef, 1'b0);
        check_val("commit_ready_o", 64'(commit_ready_o), 64'h1);
        check_val("no_st_pending_o", 64'(no_st_pending_o), 64'h0);
        flush_i = 1'b1;
        @(posedge clk_i);
        #1;
        flush_i = 1'b0;
        wait_no_pending();
        check_val("commit_ready_o", 64'(commit_ready_o), 64'h0);
        do_load(lsu_pkg::LD, DW_D);
    endtask

    // load right behind a committed store to the same dword
    task automatic test_store_then_load();
        logic [31:0] a;
        int          k;
        for (k = 0; k < 6; k++) begin
            a = 32'h0000_5000 + 32'(k * 8);
            do_store(lsu_pkg::SD, a, ~fill_word(a), 1'b1);
            do_load(lsu_pkg::LD, a);
        end
    endtask

    initial begin
        rst_ni      = 1'b0;
        flush_i     = 1'b0;
        lsu_valid_i = 1'b0;
        commit_i    = 1'b0;
        fu_data_i   = '0;
        next_id     = 3'd0;
        repeat (8) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;
        test_reset_state();
        test_sd_then_loads();
        test_partial_stores();
        test_misaligned();
        test_flush();
        test_store_then_load();
        $display("** PASS **");
        $finish;
    end

endmodule

/* lsu.f */
+incdir+include
rtl/lsu_pkg.sv
rtl/lsu_agu.sv
rtl/lsu_bypass.sv
rtl/load_unit.sv
rtl/store_unit.sv
rtl/load_store_unit.sv
tb/tb_lsu.sv

/* run_lsu.sh */
#!/bin/sh
# build the load/store unit testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_lsu \
    -f lsu.f \
    -o tb_lsu_sim

./obj_dir/tb_lsu_sim
